// ==== logic/xfcp_pkg.sv ====
package xfcp_pkg;

    // Stream byte and the beat that carries it
    typedef logic [7:0] xfcp_byte_t;

    typedef struct packed {
        xfcp_byte_t data;
        logic       last;
        // Packet marked bad, only looked at on the last beat
        logic       user;
    } xfcp_beat_t;

    // Memory bus widths
    typedef logic [7:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    typedef struct packed {
        wb_addr_t adr;
        wb_data_t dat;
        logic     we;
        logic     stb;
        logic     cyc;
    } wb_req_t;

    // Command codes
    localparam xfcp_byte_t CMD_READ  = 8'h10;
    localparam xfcp_byte_t CMD_WRITE = 8'h12;

    // ORed into the command code to form the response code
    localparam xfcp_byte_t RESP_FLAG = 8'h01;

    // Data words travel least significant byte first
    localparam int DATA_BYTES = 4;

endpackage

// ==== logic/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram (
    input  logic               clk,
    input  xfcp_pkg::wb_req_t  wb_req_i,
    output xfcp_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack_o
);
    import xfcp_pkg::*;

    localparam int WORDS = 2 ** $bits(wb_addr_t);

    wb_data_t mem [WORDS];
    logic     access;

    // Start of a cycle, ack drops in between back-to-back requests
    assign access = wb_req_i.stb && wb_req_i.cyc && !wb_ack_o;

    // Memory powers up cleared
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_ack_o <= access;
        if (access) begin
            wb_dat_o <= mem[wb_req_i.adr];
            if (wb_req_i.we) begin
                mem[wb_req_i.adr] <= wb_req_i.dat;
            end
        end
    end

endmodule

// ==== logic/xfcp_mod_wb.sv ====
`timescale 1ns/1ps

module xfcp_mod_wb (
    input  logic                 clk,
    input  logic                 rst_i,

    input  xfcp_pkg::xfcp_beat_t up_in_beat_i,
    input  logic                 up_in_valid_i,
    output logic                 up_in_ready_o,

    output xfcp_pkg::xfcp_beat_t up_out_beat_o,
    output logic                 up_out_valid_o,
    input  logic                 up_out_ready_i,

    output xfcp_pkg::wb_req_t    wb_req_o,
    input  xfcp_pkg::wb_data_t   wb_dat_i,
    input  logic                 wb_ack_i
);
    import xfcp_pkg::*;

    typedef enum logic [2:0] {CMD, ADDR, DATA, DROP, BUS, RESP} state_t;

    state_t     state_q;
    xfcp_byte_t cmd_q;
    wb_addr_t   addr_q;
    wb_data_t   data_q;
    // Data byte index while receiving, beat index while responding
    logic [2:0] cnt_q;

    logic       in_fire;
    logic       out_fire;
    logic       good_end;
    logic       is_read;
    logic [1:0] resp_byte;

    // Busy from the last command beat until the response has left
    assign up_in_ready_o = (state_q == CMD) || (state_q == ADDR) ||
                           (state_q == DATA) || (state_q == DROP);
    assign in_fire  = up_in_valid_i && up_in_ready_o;
    assign good_end = up_in_beat_i.last && !up_in_beat_i.user;
    assign is_read  = (cmd_q == CMD_READ);

    assign up_out_valid_o = (state_q == RESP);
    assign out_fire       = up_out_valid_o && up_out_ready_i;

    // Request held for the whole BUS state
    always_comb begin
        wb_req_o.adr = addr_q;
        wb_req_o.dat = data_q;
        wb_req_o.we  = !is_read;
        wb_req_o.stb = (state_q == BUS);
        wb_req_o.cyc = (state_q == BUS);
    end

    // Beats 2 to 5 carry the read word, low byte first
    assign resp_byte = cnt_q[1:0] - 2'd2;

    always_comb begin
        up_out_beat_o.user = 1'b0;
        up_out_beat_o.last = is_read ? (cnt_q == 3'(DATA_BYTES + 1)) : (cnt_q == 3'd1);
        case (cnt_q)
            3'd0:    up_out_beat_o.data = cmd_q | RESP_FLAG;
            3'd1:    up_out_beat_o.data = addr_q;
            default: up_out_beat_o.data = data_q[8*resp_byte +: 8];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= CMD;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                CMD: begin
                    if (in_fire) begin
                        if (up_in_beat_i.last) begin
                            state_q <= CMD;
                        end else if (up_in_beat_i.data == CMD_READ ||
                                     up_in_beat_i.data == CMD_WRITE) begin
                            state_q <= ADDR;
                        end else begin
                            state_q <= DROP;
                        end
                    end
                end
                ADDR: begin
                    if (in_fire) begin
                        cnt_q <= '0;
                        if (is_read) begin
                            if (good_end) begin
                                state_q <= BUS;
                            end else begin
                                state_q <= up_in_beat_i.last ? CMD : DROP;
                            end
                        end else begin
                            state_q <= up_in_beat_i.last ? CMD : DATA;
                        end
                    end
                end
                DATA: begin
                    if (in_fire) begin
                        cnt_q <= cnt_q + 3'd1;
                        if (cnt_q == 3'(DATA_BYTES - 1)) begin
                            if (good_end) begin
                                state_q <= BUS;
                            end else begin
                                state_q <= up_in_beat_i.last ? CMD : DROP;
                            end
                        end else if (up_in_beat_i.last) begin
                            // Write one or more bytes short
                            state_q <= CMD;
                        end
                    end
                end
                DROP: begin
                    if (in_fire && up_in_beat_i.last) begin
                        state_q <= CMD;
                    end
                end
                BUS: begin
                    if (wb_ack_i) begin
                        cnt_q   <= '0;
                        state_q <= RESP;
                    end
                end
                RESP: begin
                    if (out_fire) begin
                        if (up_out_beat_o.last) begin
                            state_q <= CMD;
                        end else begin
                            cnt_q <= cnt_q + 3'd1;
                        end
                    end
                end
                default: state_q <= CMD;
            endcase
        end
    end

    // Command fields and data word
    always_ff @(posedge clk) begin
        if (state_q == CMD && in_fire) begin
            cmd_q <= up_in_beat_i.data;
        end
        if (state_q == ADDR && in_fire) begin
            addr_q <= up_in_beat_i.data;
        end
        if (state_q == DATA && in_fire) begin
            data_q[8*cnt_q[1:0] +: 8] <= up_in_beat_i.data;
        end
        if (state_q == BUS && wb_ack_i && is_read) begin
            data_q <= wb_dat_i;
        end
    end

endmodule

// ==== logic/xfcp_switch.sv ====
`timescale 1ns/1ps

module xfcp_switch #(
    parameter int PORTS = 2
) (
    input  logic                                clk,
    input  logic                                rst_i,

    input  xfcp_pkg::xfcp_beat_t                up_in_beat_i,
    input  logic                                up_in_valid_i,
    output logic                                up_in_ready_o,

    output xfcp_pkg::xfcp_beat_t                up_out_beat_o,
    output logic                                up_out_valid_o,
    input  logic                                up_out_ready_i,

    output xfcp_pkg::xfcp_beat_t [PORTS-1:0]    dn_out_beat_o,
    output logic [PORTS-1:0]                    dn_out_valid_o,
    input  logic [PORTS-1:0]                    dn_out_ready_i,

    input  xfcp_pkg::xfcp_beat_t [PORTS-1:0]    dn_in_beat_i,
    input  logic [PORTS-1:0]                    dn_in_valid_i,
    output logic [PORTS-1:0]                    dn_in_ready_o
);
    import xfcp_pkg::*;

    typedef enum logic [2:0] {IDLE, FORWARD, DROP, TAG, RETURN} state_t;

    state_t     state_q;
    xfcp_byte_t port_q;
    logic       tag_valid_q;

    // Handshake of the currently selected port
    logic       sel_out_ready;
    logic       sel_in_valid;
    xfcp_beat_t sel_in_beat;

    always_comb begin
        sel_out_ready = 1'b0;
        sel_in_valid  = 1'b0;
        sel_in_beat   = '0;
        for (int k = 0; k < PORTS; k++) begin
            if (int'(port_q) == k) begin
                sel_out_ready = dn_out_ready_i[k];
                sel_in_valid  = dn_in_valid_i[k];
                sel_in_beat   = dn_in_beat_i[k];
            end
        end
    end

    always_comb begin
        up_in_ready_o  = 1'b0;
        up_out_beat_o  = '0;
        up_out_valid_o = 1'b0;
        case (state_q)
            IDLE, DROP: up_in_ready_o = 1'b1;
            FORWARD:    up_in_ready_o = sel_out_ready;
            TAG: begin
                // Port byte comes straight from its register
                up_out_beat_o.data = port_q;
                up_out_valid_o     = tag_valid_q;
            end
            RETURN: begin
                up_out_beat_o  = sel_in_beat;
                up_out_valid_o = sel_in_valid;
            end
            default: up_in_ready_o = 1'b0;
        endcase

        // Data is broadcast, valid and ready only reach the selected port
        for (int k = 0; k < PORTS; k++) begin
            dn_out_beat_o[k]  = up_in_beat_i;
            dn_out_valid_o[k] = (state_q == FORWARD) && (int'(port_q) == k) && up_in_valid_i;
            dn_in_ready_o[k]  = (state_q == RETURN) && (int'(port_q) == k) && up_out_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= IDLE;
            port_q      <= '0;
            tag_valid_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (up_in_valid_i) begin
                        port_q <= up_in_beat_i.data;
                        // A packet of only the port byte carries no command
                        if (up_in_beat_i.last) begin
                            state_q <= IDLE;
                        end else if (int'(up_in_beat_i.data) < PORTS) begin
                            state_q <= FORWARD;
                        end else begin
                            state_q <= DROP;
                        end
                    end
                end
                FORWARD: begin
                    if (up_in_valid_i && sel_out_ready && up_in_beat_i.last) begin
                        state_q <= TAG;
                    end
                end
                DROP: begin
                    if (up_in_valid_i && up_in_beat_i.last) begin
                        state_q <= IDLE;
                    end
                end
                TAG: begin
                    if (tag_valid_q) begin
                        if (up_out_ready_i) begin
                            tag_valid_q <= 1'b0;
                            state_q     <= RETURN;
                        end
                    end else if (sel_in_valid) begin
                        tag_valid_q <= 1'b1;
                    end else if (sel_out_ready) begin
                        // Endpoint is ready again without a response, so it
                        // discarded the packet
                        state_q <= IDLE;
                    end
                end
                RETURN: begin
                    if (sel_in_valid && up_out_ready_i && sel_in_beat.last) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== logic/xfcp_core.sv ====
`timescale 1ns/1ps

module xfcp_core #(
    parameter int PORTS = 2
) (
    input  logic                 clk,
    input  logic                 rst_i,

    input  xfcp_pkg::xfcp_beat_t up_in_beat_i,
    input  logic                 up_in_valid_i,
    output logic                 up_in_ready_o,

    output xfcp_pkg::xfcp_beat_t up_out_beat_o,
    output logic                 up_out_valid_o,
    input  logic                 up_out_ready_i
);
    import xfcp_pkg::*;

    // Switch to endpoint streams
    xfcp_beat_t [PORTS-1:0] dn_out_beat;
    logic [PORTS-1:0]       dn_out_valid;
    logic [PORTS-1:0]       dn_out_ready;
    xfcp_beat_t [PORTS-1:0] dn_in_beat;
    logic [PORTS-1:0]       dn_in_valid;
    logic [PORTS-1:0]       dn_in_ready;

    // Endpoint to RAM buses
    wb_req_t [PORTS-1:0]    wb_req;
    wb_data_t [PORTS-1:0]   wb_dat;
    logic [PORTS-1:0]       wb_ack;

    xfcp_switch #(
        .PORTS(PORTS)
    ) switch_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .up_in_beat_i   (up_in_beat_i),
        .up_in_valid_i  (up_in_valid_i),
        .up_in_ready_o  (up_in_ready_o),
        .up_out_beat_o  (up_out_beat_o),
        .up_out_valid_o (up_out_valid_o),
        .up_out_ready_i (up_out_ready_i),
        .dn_out_beat_o  (dn_out_beat),
        .dn_out_valid_o (dn_out_valid),
        .dn_out_ready_i (dn_out_ready),
        .dn_in_beat_i   (dn_in_beat),
        .dn_in_valid_i  (dn_in_valid),
        .dn_in_ready_o  (dn_in_ready)
    );

    // One bridge and memory per switch port
    for (genvar k = 0; k < PORTS; k++) begin : g_port
        xfcp_mod_wb mod_wb_inst (
            .clk            (clk),
            .rst_i          (rst_i),
            .up_in_beat_i   (dn_out_beat[k]),
            .up_in_valid_i  (dn_out_valid[k]),
            .up_in_ready_o  (dn_out_ready[k]),
            .up_out_beat_o  (dn_in_beat[k]),
            .up_out_valid_o (dn_in_valid[k]),
            .up_out_ready_i (dn_in_ready[k]),
            .wb_req_o       (wb_req[k]),
            .wb_dat_i       (wb_dat[k]),
            .wb_ack_i       (wb_ack[k])
        );

        wb_ram ram_inst (
            .clk      (clk),
            .wb_req_i (wb_req[k]),
            .wb_dat_o (wb_dat[k]),
            .wb_ack_o (wb_ack[k])
        );
    end

endmodule

// ==== sim/xfcp_core_sva.sv ====
`timescale 1ns/1ps

module xfcp_core_sva (
    input logic                 clk,
    input logic                 rst_i,
    input xfcp_pkg::wb_req_t    wb_req_o,
    input logic                 wb_ack_i,
    input xfcp_pkg::xfcp_beat_t up_out_beat_o,
    input logic                 up_out_valid_o,
    input logic                 up_out_ready_i
);

    // Strobe only inside a bus cycle
    stb_in_cycle: assert property (@(posedge clk) disable iff (rst_i)
        wb_req_o.stb |-> wb_req_o.cyc)
        else $error("wb stb high without cyc");

    // Stalled response beat stays put
    out_hold: assert property (@(posedge clk) disable iff (rst_i)
        up_out_valid_o && !up_out_ready_i |=> up_out_valid_o && $stable(up_out_beat_o))
        else $error("response beat changed while stalled");

    // One access per command
    stb_drop: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_i |=> !wb_req_o.stb)
        else $error("wb stb still high after ack");

endmodule

bind xfcp_mod_wb xfcp_core_sva sva_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .wb_req_o       (wb_req_o),
    .wb_ack_i       (wb_ack_i),
    .up_out_beat_o  (up_out_beat_o),
    .up_out_valid_o (up_out_valid_o),
    .up_out_ready_i (up_out_ready_i)
);

// ==== sim/tb_xfcp_core.sv ====
`timescale 1ns/1ps

module tb_xfcp_core;
    import xfcp_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst_i;
    xfcp_beat_t  up_in_beat_i;
    logic        up_in_valid_i;
    logic        up_in_ready_o;
    xfcp_beat_t  up_out_beat_o;
    logic        up_out_valid_o;
    logic        up_out_ready_i;

    // Expected memory contents per port
    wb_data_t    ref_mem [2][256];
    logic [31:0] rng;
    logic        throttle;
    int          errors;
    int          tests_run;

    xfcp_core #(
        .PORTS(2)
    ) DUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .up_in_beat_i   (up_in_beat_i),
        .up_in_valid_i  (up_in_valid_i),
        .up_in_ready_o  (up_in_ready_o),
        .up_out_beat_o  (up_out_beat_o),
        .up_out_valid_o (up_out_valid_o),
        .up_out_ready_i (up_out_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    // Beats change 1 ns after the edge, ready is sampled at the falling edge
    task automatic send_packet(input xfcp_byte_t bytes[$], input logic bad);
        int wait_cnt;
        for (int i = 0; i < bytes.size(); i++) begin
            up_in_beat_i.data = bytes[i];
            up_in_beat_i.last = (i == bytes.size() - 1);
            up_in_beat_i.user = bad && (i == bytes.size() - 1);
            up_in_valid_i     = 1'b1;
            wait_cnt          = 0;
            @(negedge clk);
            while (!up_in_ready_o && wait_cnt < TIMEOUT) begin
                wait_cnt++;
                @(negedge clk);
            end
            if (!up_in_ready_o) begin
                abort_on_timeout("up_in_ready_o");
            end
            @(posedge clk);
            #1;
        end
        up_in_valid_i = 1'b0;
        up_in_beat_i  = '0;
    endtask

    task automatic recv_packet(output xfcp_byte_t bytes[$]);
        int          wait_cnt;
        logic        done;
        logic [31:0] r;
        bytes    = {};
        wait_cnt = 0;
        done     = 1'b0;
        while (!done && wait_cnt < TIMEOUT) begin
            r = xorshift32();
            up_out_ready_i = throttle ? r[9] : 1'b1;
            @(negedge clk);
            // Upstream stays closed until the response is out
            assert (!up_in_ready_o) else begin
                $display("[FAIL] up_in_ready_o: got %h expected 0", up_in_ready_o);
                errors++;
            end
            if (up_out_valid_o && up_out_ready_i) begin
                // Responses are never marked bad
                assert (!up_out_beat_o.user) else begin
                    $display("[FAIL] up_out_beat_o.user: got %h expected 0",
                             up_out_beat_o.user);
                    errors++;
                end
                bytes.push_back(up_out_beat_o.data);
                done     = up_out_beat_o.last;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
            end
            @(posedge clk);
            #1;
        end
        up_out_ready_i = 1'b1;
        if (!done) begin
            abort_on_timeout("a response beat");
        end
    endtask

    task automatic expect_silence();
        up_out_ready_i = 1'b1;
        repeat (40) begin
            @(negedge clk);
            assert (!up_out_valid_o) else begin
                $display("[FAIL] up_out_valid_o: got %h expected 0", up_out_valid_o);
                errors++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compare_packet(input xfcp_byte_t got[$], input xfcp_byte_t exp[$]);
        assert (got.size() == exp.size()) else begin
            $display("[FAIL] up_out_beat_o beat count: got %0h expected %0h",
                     got.size(), exp.size());
            errors++;
        end
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            assert (got[i] == exp[i]) else begin
                $display("[FAIL] up_out_beat_o.data beat %0d: got %h expected %h",
                         i, got[i], exp[i]);
                errors++;
            end
        end
    endtask

    task automatic do_write(input xfcp_byte_t port, input wb_addr_t addr, input wb_data_t data);
        xfcp_byte_t pkt[$];
        xfcp_byte_t resp[$];
        xfcp_byte_t exp[$];
        pkt = {port, CMD_WRITE, addr};
        for (int b = 0; b < DATA_BYTES; b++) begin
            pkt.push_back(data[8*b +: 8]);
        end
        send_packet(pkt, 1'b0);
        recv_packet(resp);
        exp = {port, 8'h13, addr};
        compare_packet(resp, exp);
        ref_mem[port[0]][addr] = data;
    endtask

    task automatic do_read(input xfcp_byte_t port, input wb_addr_t addr,
                           output xfcp_byte_t resp[$]);
        xfcp_byte_t pkt[$];
        xfcp_byte_t exp[$];
        wb_data_t   word;
        pkt = {port, CMD_READ, addr};
        send_packet(pkt, 1'b0);
        recv_packet(resp);
        word = ref_mem[port[0]][addr];
        exp  = {port, 8'h11, addr};
        for (int b = 0; b < DATA_BYTES; b++) begin
            exp.push_back(word[8*b +: 8]);
        end
        compare_packet(resp, exp);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    task automatic test_write_read();
        int         start;
        xfcp_byte_t resp[$];
        start = errors;
        do_write(8'd0, 8'h21, 32'hcafe0123);
        do_read(8'd0, 8'h21, resp);
        report_test("write_read", start);
    endtask

    task automatic test_port_independence();
        int         start;
        xfcp_byte_t resp[$];
        start = errors;
        do_write(8'd0, 8'h35, 32'h0badf00d);
        do_write(8'd1, 8'h35, 32'h76543210);
        do_read(8'd0, 8'h35, resp);
        do_read(8'd1, 8'h35, resp);
        report_test("port_independence", start);
    endtask

    task automatic test_bad_packets();
        int         start;
        xfcp_byte_t pkt[$];
        xfcp_byte_t resp[$];
        start = errors;
        do_write(8'd0, 8'h40, 32'h11223344);
        do_write(8'd1, 8'h40, 32'h55667788);
        // Port out of range
        pkt = {8'd2, CMD_WRITE, 8'h40, 8'hde, 8'had, 8'hbe, 8'hef};
        send_packet(pkt, 1'b0);
        expect_silence();
        // Unknown command
        pkt = {8'd0, 8'h20, 8'h40, 8'hde, 8'had, 8'hbe, 8'hef};
        send_packet(pkt, 1'b0);
        expect_silence();
        // Write one byte short
        pkt = {8'd0, CMD_WRITE, 8'h40, 8'hde, 8'had, 8'hbe};
        send_packet(pkt, 1'b0);
        expect_silence();
        // Read with a trailing byte
        pkt = {8'd0, CMD_READ, 8'h40, 8'h00};
        send_packet(pkt, 1'b0);
        expect_silence();
        // Complete write marked bad
        pkt = {8'd1, CMD_WRITE, 8'h40, 8'hde, 8'had, 8'hbe, 8'hef};
        send_packet(pkt, 1'b1);
        expect_silence();
        do_read(8'd0, 8'h40, resp);
        do_read(8'd1, 8'h40, resp);
        report_test("bad_packets", start);
    endtask

    task automatic test_backpressure();
        int         start;
        xfcp_byte_t plain[$];
        xfcp_byte_t slow[$];
        start = errors;
        do_write(8'd1, 8'h5a, 32'h89abcdef);
        throttle = 1'b0;
        do_read(8'd1, 8'h5a, plain);
        throttle = 1'b1;
        do_read(8'd1, 8'h5a, slow);
        throttle = 1'b0;
        compare_packet(slow, plain);
        report_test("backpressure", start);
    endtask

    task automatic test_random();
        int          start;
        logic [31:0] r;
        xfcp_byte_t  resp[$];
        start = errors;
        for (int n = 0; n < 20; n++) begin
            r = xorshift32();
            // Small address window so reads hit earlier writes
            if (r[20]) begin
                do_write({7'd0, r[0]}, {4'h6, r[11:8]}, xorshift32());
            end else begin
                do_read({7'd0, r[0]}, {4'h6, r[11:8]}, resp);
            end
        end
        report_test("random", start);
    endtask

    initial begin
        rst_i          = 1'b1;
        up_in_beat_i   = '0;
        up_in_valid_i  = 1'b0;
        up_out_ready_i = 1'b1;
        throttle       = 1'b0;
        rng            = 32'hd1f;
        errors         = 0;
        tests_run      = 0;
        for (int p = 0; p < 2; p++) begin
            for (int a = 0; a < 256; a++) begin
                ref_mem[p][a] = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;

        test_write_read();
        test_port_independence();
        test_bad_packets();
        test_backpressure();
        test_random();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/xfcp_pkg.sv
logic/wb_ram.sv
logic/xfcp_mod_wb.sv
logic/xfcp_switch.sv
logic/xfcp_core.sv
sim/xfcp_core_sva.sv
sim/tb_xfcp_core.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_xfcp_core

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard logic/*.sv sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_xfcp_core -f verilog.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
